// File: sim/programInput.hex
// @000 program words, @100 initial data words (byte address 0x400)
// @200 expected stores, one per line as test tag, byte address, value
@000
00700093
ffd00113
002081b3
40208233
001122b3
00113333
401153b3
00415413
00309493
0f00c513
0090e5b3
0ff17613
00508013
60302023
60402223
60502423
60602623
60702823
60802a23
60902c23
60a02e23
62b02023
62c02223
62002423
06400693
01468693
00d68733
60e02023
40002783
00178813
61002223
60f02423
40402883
40802903
40c02983
61102623
61202823
61302a23
00108463
62102e23
00109463
60102c23
00114463
62102e23
00115463
60202e23
00116463
62102023
00117463
62102e23
00c00aef
62102e23
62102e23
63502223
0e800b13
001b0be7
62102e23
62102e23
63702423
abcdec37
00012c97
63802623
63902823
0000006f
@100
12345678
80000001
cafef00d
000000ff
@200
00000001 00000600 00000004
00000001 00000604 0000000a
00000001 00000608 00000001
00000001 0000060c 00000000
00000001 00000610 ffffffff
00000001 00000614 0fffffff
00000001 00000618 00000038
00000001 0000061c 000000f7
00000001 00000620 0000003f
00000001 00000624 000000fd
00000001 00000628 00000000
00000002 00000600 000000f0
00000002 00000604 12345679
00000002 00000608 12345678
00000003 0000060c 80000001
00000003 00000610 cafef00d
00000003 00000614 000000ff
00000004 00000618 00000007
00000004 0000061c fffffffd
00000004 00000620 00000007
00000004 00000624 000000cc
00000004 00000628 000000e0
00000005 0000062c abcde000
00000005 00000630 000120f0

// File: list.f
design/riscvPkg.sv
design/regFile.sv
design/fetchUnit.sv
design/instrDecode.sv
design/aluExecute.sv
design/resultStage.sv
design/riscv150.sv
sim/clockGen.sv
sim/tbRiscv150.sv

// File: Makefile
SIM = verilator
FLAGS = --binary --timing --assert -j 0
TOP = tbRiscv150
FILELIST = list.f
BUILD = obj_dir
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with $(SIM), run and check $(LOG) for the fail message"
	@echo "  clean  remove $(BUILD) and $(LOG)"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "=== PASS ===" $(LOG); then echo "Simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)

// File: sim/tbRiscv150.sv
// Testbench for riscv150, runs the program from the input data file under random stall and checks stores
`timescale 1ns/100ps
`default_nettype none

module tbRiscv150;

   localparam int memWords = 4096;
   localparam int fileWords = 1024;
   localparam int dataBase = 256;
   localparam int expBase = 512;
   localparam int maxExp = 150;
   localparam int maxCycles = 5000;
   localparam int drainCycles = 60;
   localparam int numTests = 6;
   localparam int stallTest = 6;
   localparam logic [31:0] nopWord = 32'h0000_0013;
   localparam logic [31:0] endMark = 32'hffff_ffff;

   bit clk;
   logic rst;
   logic stall;
   logic [31:0] icacheAddr;
   logic [31:0] instruction;
   logic [31:0] dcacheAddr;
   logic dcacheRe;
   logic [3:0] dcacheWe;
   logic [31:0] dcacheDin;
   logic [31:0] dcacheDout;

   logic [31:0] fileMem [0:fileWords-1];
   logic [31:0] imem [0:memWords-1];
   logic [31:0] dmem [0:memWords-1];
   int expTag [0:maxExp-1];
   logic [31:0] expAddr [0:maxExp-1];
   logic [31:0] expVal [0:maxExp-1];

   logic [31:0] iAddrQ;
   logic [31:0] rdData;
   logic [31:0] lfsr;
   logic bitA;
   logic bitB;
   int resetLeft;
   int numExp;
   int storeIdx;
   int stallCycles;
   int errCount [1:numTests];
   int totalErrors;
   int failedTests;
   int cycles;
   bit timedOut;
   bit setupFailed;

   clockGen #(.periodNs(40)) u_clockGen (.clk(clk));

   riscv150 #(.pcWidth(14)) u_riscv150 (
      .clk(clk), .rst(rst), .stall(stall),
      .icacheAddr(icacheAddr), .instruction(instruction),
      .dcacheAddr(dcacheAddr), .dcacheRe(dcacheRe), .dcacheWe(dcacheWe),
      .dcacheDin(dcacheDin), .dcacheDout(dcacheDout)
   );

   // Galois form, taps 32 22 2 1
   function automatic logic [31:0] lfsrStep(input logic [31:0] s);
      if (s[0])
         return (s >> 1) ^ 32'h8020_0003;
      return s >> 1;
   endfunction

   task automatic takeBit(output logic b);
      b = lfsr[0];
      lfsr = lfsrStep(lfsr);
   endtask

   function automatic string testName(input int tag);
      case (tag)
         1: return "arith";
         2: return "forwarding";
         3: return "loads";
         4: return "controlFlow";
         5: return "upperImm";
         default: return "stall";
      endcase
   endfunction

   task automatic reportTest(input int tag);
      $display("test %s %s, %0d errors", testName(tag),
               (errCount[tag] == 0) ? "ok" : "failed", errCount[tag]);
   endtask

   task automatic checkStore(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] we);
      int tag;
      if (storeIdx >= numExp)
      begin
         errCount[stallTest]++;
         $display("Unexpected extra store of %h to address %h after the last expected store",
                  data, addr);
      end
      else
      begin
         tag = expTag[storeIdx];
         if (tag < 1 || tag > numTests - 1)
            tag = stallTest;
         if (addr !== expAddr[storeIdx] || data !== expVal[storeIdx])
         begin
            errCount[tag]++;
            $display("MISMATCH %s store %0d expected %h at %h actual %h at %h", testName(tag),
                     storeIdx, expVal[storeIdx], expAddr[storeIdx], data, addr);
         end
         // SW writes all four bytes
         if (we !== 4'b1111)
         begin
            errCount[tag]++;
            $display("MISMATCH %s store %0d write enables expected %h actual %h",
                     testName(tag), storeIdx, 4'b1111, we);
         end
         storeIdx++;
         // Last store of a group closes that test
         if (storeIdx == numExp || expTag[storeIdx] != expTag[storeIdx - 1])
            reportTest(tag);
      end
   endtask

   // Memory side sees the DUT outputs as they were just before the edge
   always @(posedge clk)
   begin
      iAddrQ = icacheAddr;
      if (!rst)
      begin
         if (stall)
            stallCycles++;
         if (stall && (dcacheRe || dcacheWe != 4'b0))
         begin
            errCount[stallTest]++;
            $display("Data memory was accessed at %h while stall was high", dcacheAddr);
         end
         if (icacheAddr[1:0] != 2'b00 || icacheAddr >= 32'(4 * memWords))
         begin
            errCount[stallTest]++;
            $display("Instruction address %h is unaligned or outside the memory", icacheAddr);
         end
         if (dcacheRe)
            rdData = dmem[dcacheAddr[13:2]];
         if (dcacheWe != 4'b0)
         begin
            checkStore(dcacheAddr, dcacheDin, dcacheWe);
            dmem[dcacheAddr[13:2]] = dcacheDin;
         end
      end
   end

   // All DUT inputs change here
   always @(negedge clk)
   begin
      instruction <= imem[iAddrQ[13:2]];
      dcacheDout <= rdData;
      if (resetLeft > 0)
      begin
         resetLeft--;
         if (resetLeft == 0)
            rst <= 1'b0;
      end
      else
      begin
         takeBit(bitA);
         takeBit(bitB);
         stall <= bitA & bitB;
      end
   end

   initial
   begin
      rst = 1'b1;
      stall = 1'b0;
      instruction = nopWord;
      dcacheDout = '0;
      iAddrQ = '0;
      rdData = '0;
      lfsr = 32'h3cec_7302;
      resetLeft = 16;
      numExp = 0;
      storeIdx = 0;
      stallCycles = 0;
      totalErrors = 0;
      failedTests = 0;
      timedOut = 1'b0;
      setupFailed = 1'b0;
      for (int t = 1; t <= numTests; t++)
         errCount[t] = 0;
      for (int i = 0; i < fileWords; i++)
         fileMem[i] = endMark;
      $readmemh("sim/programInput.hex", fileMem);

      for (int i = 0; i < memWords; i++)
      begin
         imem[i] = nopWord;
         dmem[i] = 32'h5a00_0000 | 32'(i);
      end
      for (int i = 0; i < dataBase; i++)
      begin
         if (fileMem[i] != endMark)
            imem[i] = fileMem[i];
         if (fileMem[dataBase + i] != endMark)
            dmem[dataBase + i] = fileMem[dataBase + i];
      end
      while (numExp < maxExp && fileMem[expBase + 3 * numExp] != endMark)
      begin
         expTag[numExp] = int'(fileMem[expBase + 3 * numExp]);
         expAddr[numExp] = fileMem[expBase + 3 * numExp + 1];
         expVal[numExp] = fileMem[expBase + 3 * numExp + 2];
         numExp++;
      end
      if (numExp == 0)
      begin
         setupFailed = 1'b1;
         $display("No expected stores were found in the input data file");
      end

      cycles = 0;
      while (storeIdx < numExp && !timedOut)
      begin
         @(negedge clk);
         cycles++;
         if (cycles >= maxCycles)
            timedOut = 1'b1;
      end
      if (timedOut)
         $display("Timeout, only %0d of %0d expected stores seen after %0d cycles",
                  storeIdx, numExp, cycles);

      // Keep running so that stray stores after the last one are caught
      for (int i = 0; i < drainCycles; i++)
         @(negedge clk);
      if (stallCycles == 0)
      begin
         errCount[stallTest]++;
         $display("Stall was never raised during the run");
      end
      reportTest(stallTest);

      for (int t = 1; t <= numTests; t++)
      begin
         totalErrors += errCount[t];
         if (errCount[t] != 0)
            failedTests++;
      end
      $display("Totals %0d tests, %0d failed, %0d of %0d stores checked, %0d errors",
               numTests, failedTests, storeIdx, numExp, totalErrors);
      if (totalErrors == 0 && !timedOut && !setupFailed)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   end

endmodule

`default_nettype wire

// File: sim/clockGen.sv
// Testbench clock source, free-running from time zero with a configurable period in ns
`timescale 1ns/100ps
`default_nettype none

module clockGen #(
   parameter int periodNs = 40
) (
   output bit clk
);

   // Starts low with no edge at time zero
   initial
   begin
      clk = 1'b0;
   end

   always #(periodNs / 2) clk = ~clk;

endmodule

`default_nettype wire

// File: design/riscv150.sv
// Top level of the RV32I pipeline, memories attach through the icache and dcache ports
`timescale 1ns/100ps
`default_nettype none

module riscv150 #(
   parameter int pcWidth = 14
) (
   input wire clk,
   input wire rst,
   input wire stall,
   output riscvPkg::word_t icacheAddr,
   input wire riscvPkg::word_t instruction,
   output riscvPkg::word_t dcacheAddr,
   output logic dcacheRe,
   output logic [3:0] dcacheWe,
   output riscvPkg::word_t dcacheDin,
   // Must hold its last read while dcacheRe is low
   input wire riscvPkg::word_t dcacheDout
);

   logic redirect;
   logic [pcWidth-1:0] redirectPc;
   logic [pcWidth-1:0] exPc;
   logic exValid;
   riscvPkg::decodeCtrl_t ctrl;
   riscvPkg::word_t rd1;
   riscvPkg::word_t rd2;
   riscvPkg::wbBus_t toWb;
   riscvPkg::wbBus_t wbFwd;
   riscvPkg::word_t wbValue;
   logic wrEn;
   riscvPkg::regAddr_t wrAddr;
   riscvPkg::word_t wrData;

   fetchUnit #(.pcWidth(pcWidth)) u_fetchUnit (
      .clk(clk), .rst(rst), .stall(stall),
      .redirect(redirect), .redirectPc(redirectPc),
      .icacheAddr(icacheAddr), .exPc(exPc), .exValid(exValid)
   );

   instrDecode u_instrDecode (
      .instruction(instruction), .ctrl(ctrl)
   );

   regFile u_regFile (
      .clk(clk), .rst(rst),
      .rs1(ctrl.rs1), .rs2(ctrl.rs2), .rd1(rd1), .rd2(rd2),
      .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData)
   );

   aluExecute #(.pcWidth(pcWidth)) u_aluExecute (
      .clk(clk), .rst(rst), .stall(stall),
      .ctrl(ctrl), .rd1(rd1), .rd2(rd2), .exPc(exPc), .exValid(exValid),
      .wbFwd(wbFwd), .wbValue(wbValue),
      .redirect(redirect), .redirectPc(redirectPc),
      .dcacheAddr(dcacheAddr), .dcacheRe(dcacheRe), .dcacheWe(dcacheWe),
      .dcacheDin(dcacheDin), .toWb(toWb)
   );

   resultStage u_resultStage (
      .clk(clk), .rst(rst), .stall(stall),
      .toWb(toWb), .dcacheDout(dcacheDout),
      .wbFwd(wbFwd), .wbValue(wbValue),
      .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData)
   );

endmodule

`default_nettype wire

// File: design/resultStage.sv
// Writeback stage, picks the result for the register file and feeds it back for forwarding
`timescale 1ns/100ps
`default_nettype none

module resultStage (
   input wire clk,
   input wire rst,
   input wire stall,
   input wire riscvPkg::wbBus_t toWb,
   input wire riscvPkg::word_t dcacheDout,
   output riscvPkg::wbBus_t wbFwd,
   output riscvPkg::word_t wbValue,
   output logic wrEn,
   output riscvPkg::regAddr_t wrAddr,
   output riscvPkg::word_t wrData
);

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         wbFwd <= '0;
      end
      else if (!stall)
      begin
         wbFwd <= toWb;
      end
   end

   // Load data arrives from memory in this cycle
   always_comb
   begin
      case (wbFwd.resultSel)
         riscvPkg::resLoad: wbValue = dcacheDout;
         riscvPkg::resLink: wbValue = wbFwd.linkPc;
         default: wbValue = wbFwd.aluResult;
      endcase
   end

   assign wrEn = wbFwd.valid && wbFwd.regWrite && wbFwd.rd != '0 && !stall;
   assign wrAddr = wbFwd.rd;
   assign wrData = wbValue;

endmodule

`default_nettype wire

// File: design/aluExecute.sv
// Execute stage with forwarding, ALU, branch and jump resolution and the data memory request
`timescale 1ns/100ps
`default_nettype none

module aluExecute #(
   parameter int pcWidth = 14
) (
   input wire clk,
   input wire rst,
   input wire stall,
   input wire riscvPkg::decodeCtrl_t ctrl,
   input wire riscvPkg::word_t rd1,
   input wire riscvPkg::word_t rd2,
   input wire logic [pcWidth-1:0] exPc,
   input wire exValid,
   input wire riscvPkg::wbBus_t wbFwd,
   input wire riscvPkg::word_t wbValue,
   output logic redirect,
   output logic [pcWidth-1:0] redirectPc,
   output riscvPkg::word_t dcacheAddr,
   output logic dcacheRe,
   output logic [3:0] dcacheWe,
   output riscvPkg::word_t dcacheDin,
   output riscvPkg::wbBus_t toWb
);

   logic wbWrites;
   logic taken;
   logic isJump;
   logic memEnable;
   riscvPkg::word_t srcA;
   riscvPkg::word_t srcB;
   riscvPkg::word_t opA;
   riscvPkg::word_t opB;
   riscvPkg::word_t aluResult;
   riscvPkg::word_t branchTarget;
   riscvPkg::word_t nextPc;

   // Writeback result bypasses the file for the instruction right behind it
   assign wbWrites = wbFwd.valid && wbFwd.regWrite && wbFwd.rd != '0;
   assign srcA = (wbWrites && wbFwd.rd == ctrl.rs1) ? wbValue : rd1;
   assign srcB = (wbWrites && wbFwd.rd == ctrl.rs2) ? wbValue : rd2;

   assign opA = ctrl.zeroA ? '0 : (ctrl.usePc ? riscvPkg::word_t'(exPc) : srcA);
   assign opB = ctrl.useImm ? ctrl.imm : srcB;

   always_comb
   begin
      case (ctrl.aluOp)
         riscvPkg::aluAdd: aluResult = opA + opB;
         riscvPkg::aluSub: aluResult = opA - opB;
         riscvPkg::aluSll: aluResult = opA << opB[4:0];
         riscvPkg::aluSlt: aluResult = {31'b0, $signed(opA) < $signed(opB)};
         riscvPkg::aluSltu: aluResult = {31'b0, opA < opB};
         riscvPkg::aluXor: aluResult = opA ^ opB;
         riscvPkg::aluSrl: aluResult = opA >> opB[4:0];
         riscvPkg::aluSra: aluResult = $signed(opA) >>> opB[4:0];
         riscvPkg::aluOr: aluResult = opA | opB;
         riscvPkg::aluAnd: aluResult = opA & opB;
         riscvPkg::aluPassB: aluResult = opB;
         default: aluResult = '0;
      endcase
   end

   always_comb
   begin
      case (ctrl.branchFunct3)
         3'b000: taken = srcA == srcB;
         3'b001: taken = srcA != srcB;
         3'b100: taken = $signed(srcA) < $signed(srcB);
         3'b101: taken = $signed(srcA) >= $signed(srcB);
         3'b110: taken = srcA < srcB;
         3'b111: taken = srcA >= srcB;
         default: taken = 1'b0;
      endcase
   end

   // Jump targets come out of the ALU, JALR drops bit 0
   assign isJump = ctrl.isJal || ctrl.isJalr;
   assign branchTarget = riscvPkg::word_t'(exPc) + ctrl.imm;
   assign nextPc = isJump ? {aluResult[31:1], aluResult[0] & !ctrl.isJalr} : branchTarget;
   assign redirect = exValid && (isJump || (ctrl.isBranch && taken));
   assign redirectPc = nextPc[pcWidth-1:0];

   assign memEnable = exValid && !stall;
   assign dcacheAddr = aluResult;
   assign dcacheRe = memEnable && ctrl.memRead;
   assign dcacheWe = {4{memEnable && ctrl.memWrite}};
   assign dcacheDin = srcB;

   always_comb
   begin
      toWb.valid = exValid;
      toWb.regWrite = ctrl.regWrite;
      toWb.rd = ctrl.rd;
      toWb.resultSel = ctrl.resultSel;
      toWb.aluResult = aluResult;
      toWb.linkPc = riscvPkg::word_t'(exPc + pcWidth'(4));
   end

   // Decode never asks for a load and a store at once
   assert property (@(posedge clk) disable iff (rst) !(dcacheRe && dcacheWe != 4'b0));

endmodule

`default_nettype wire

// File: design/instrDecode.sv
// Combinational decoder turning the execute-stage instruction word into the control bundle
`timescale 1ns/100ps
`default_nettype none

module instrDecode (
   input wire riscvPkg::word_t instruction,
   output riscvPkg::decodeCtrl_t ctrl
);

   logic knownOpcode;
   riscvPkg::word_t instr;
   riscvPkg::opcode_t opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;
   riscvPkg::word_t immI;
   riscvPkg::word_t immS;
   riscvPkg::word_t immB;
   riscvPkg::word_t immU;
   riscvPkg::word_t immJ;
   riscvPkg::aluOp_t arithOp;

   always_comb
   begin
      case (instruction[6:0])
         riscvPkg::opcOp, riscvPkg::opcOpImm, riscvPkg::opcLui, riscvPkg::opcAuipc,
         riscvPkg::opcJal, riscvPkg::opcJalr, riscvPkg::opcBranch, riscvPkg::opcLoad,
         riscvPkg::opcStore: knownOpcode = 1'b1;
         default: knownOpcode = 1'b0;
      endcase
   end

   // Anything outside the subset runs as a plain nop
   assign instr = knownOpcode ? instruction : riscvPkg::nop;

   assign opcode = instr[6:0];
   assign funct3 = instr[14:12];
   assign funct7 = instr[31:25];

   assign immI = {{20{instr[31]}}, instr[31:20]};
   assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
   assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
   assign immU = {instr[31:12], 12'b0};
   assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

   // Bit 30 picks sub and sra; addi has no sub form
   always_comb
   begin
      case (funct3)
         3'b000: arithOp = (opcode == riscvPkg::opcOp && funct7[5]) ?
                           riscvPkg::aluSub : riscvPkg::aluAdd;
         3'b001: arithOp = riscvPkg::aluSll;
         3'b010: arithOp = riscvPkg::aluSlt;
         3'b011: arithOp = riscvPkg::aluSltu;
         3'b100: arithOp = riscvPkg::aluXor;
         3'b101: arithOp = funct7[5] ? riscvPkg::aluSra : riscvPkg::aluSrl;
         3'b110: arithOp = riscvPkg::aluOr;
         default: arithOp = riscvPkg::aluAnd;
      endcase
   end

   always_comb
   begin
      ctrl = '0;
      ctrl.aluOp = riscvPkg::aluAdd;
      ctrl.resultSel = riscvPkg::resAlu;
      ctrl.rd = instr[11:7];
      ctrl.rs1 = instr[19:15];
      ctrl.rs2 = instr[24:20];
      ctrl.branchFunct3 = funct3;
      case (opcode)
         riscvPkg::opcOp:
         begin
            ctrl.aluOp = arithOp;
            ctrl.regWrite = 1'b1;
         end
         riscvPkg::opcOpImm:
         begin
            ctrl.aluOp = arithOp;
            ctrl.useImm = 1'b1;
            ctrl.regWrite = 1'b1;
            ctrl.imm = immI;
         end
         riscvPkg::opcLui:
         begin
            ctrl.aluOp = riscvPkg::aluPassB;
            ctrl.zeroA = 1'b1;
            ctrl.useImm = 1'b1;
            ctrl.regWrite = 1'b1;
            ctrl.imm = immU;
         end
         riscvPkg::opcAuipc:
         begin
            ctrl.usePc = 1'b1;
            ctrl.useImm = 1'b1;
            ctrl.regWrite = 1'b1;
            ctrl.imm = immU;
         end
         riscvPkg::opcJal:
         begin
            ctrl.isJal = 1'b1;
            ctrl.usePc = 1'b1;
            ctrl.useImm = 1'b1;
            ctrl.regWrite = 1'b1;
            ctrl.resultSel = riscvPkg::resLink;
            ctrl.imm = immJ;
         end
         riscvPkg::opcJalr:
         begin
            ctrl.isJalr = 1'b1;
            ctrl.useImm = 1'b1;
            ctrl.regWrite = 1'b1;
            ctrl.resultSel = riscvPkg::resLink;
            ctrl.imm = immI;
         end
         riscvPkg::opcBranch:
         begin
            ctrl.isBranch = 1'b1;
            ctrl.imm = immB;
         end
         riscvPkg::opcLoad:
         begin
            ctrl.memRead = 1'b1;
            ctrl.useImm = 1'b1;
            ctrl.regWrite = 1'b1;
            ctrl.resultSel = riscvPkg::resLoad;
            ctrl.imm = immI;
         end
         riscvPkg::opcStore:
         begin
            ctrl.memWrite = 1'b1;
            ctrl.useImm = 1'b1;
            ctrl.imm = immS;
         end
         default: ctrl.regWrite = 1'b0;
      endcase
   end

endmodule

`default_nettype wire

// File: design/fetchUnit.sv
// Fetch stage, keeps the PC and hands the fetched address to execute with its valid bit
`timescale 1ns/100ps
`default_nettype none

module fetchUnit #(
   parameter int pcWidth = 14
) (
   input wire clk,
   input wire rst,
   input wire stall,
   input wire redirect,
   input wire logic [pcWidth-1:0] redirectPc,
   output riscvPkg::word_t icacheAddr,
   output logic [pcWidth-1:0] exPc,
   output logic exValid
);

   logic [pcWidth-1:0] pc;

   // Instruction memory reads every cycle, so a stall re-reads the word now in execute
   assign icacheAddr = riscvPkg::word_t'(stall ? exPc : pc);

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         pc <= '0;
         exPc <= '0;
         exValid <= 1'b0;
      end
      else if (!stall)
      begin
         exPc <= pc;
         // Word fetched in the redirect cycle is off the taken path
         exValid <= !redirect;
         pc <= redirect ? redirectPc : pc + pcWidth'(4);
      end
   end

   // Redirect targets from execute must stay word aligned
   assert property (@(posedge clk) disable iff (rst) icacheAddr[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: design/regFile.sv
// Integer register file with two combinational read ports and one write port, x0 tied to zero
`timescale 1ns/100ps
`default_nettype none

module regFile (
   input wire clk,
   input wire rst,
   input wire riscvPkg::regAddr_t rs1,
   input wire riscvPkg::regAddr_t rs2,
   output riscvPkg::word_t rd1,
   output riscvPkg::word_t rd2,
   input wire wrEn,
   input wire riscvPkg::regAddr_t wrAddr,
   input wire riscvPkg::word_t wrData
);

   // x0 keeps a slot that only reset writes
   riscvPkg::word_t regs [0:31];

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         regs[0] <= '0;
      end
      else if (wrEn && wrAddr != '0)
      begin
         regs[wrAddr] <= wrData;
      end
   end

   assign rd1 = regs[rs1];
   assign rd2 = regs[rs2];

   // Writes aimed at x0 never reach its slot
   assert property (@(posedge clk) disable iff (rst) rs1 == '0 |-> rd1 == '0);

endmodule

`default_nettype wire

// File: design/riscvPkg.sv
// Shared widths, encodings and pipeline bundles for the three-stage RV32I core
`default_nettype none

package riscvPkg;

   typedef logic [31:0] word_t;
   typedef logic [4:0] regAddr_t;
   typedef logic [3:0] aluOp_t;
   typedef logic [1:0] resultSel_t;
   typedef logic [6:0] opcode_t;

   localparam aluOp_t aluAdd = 4'd0;
   localparam aluOp_t aluSub = 4'd1;
   localparam aluOp_t aluSll = 4'd2;
   localparam aluOp_t aluSlt = 4'd3;
   localparam aluOp_t aluSltu = 4'd4;
   localparam aluOp_t aluXor = 4'd5;
   localparam aluOp_t aluSrl = 4'd6;
   localparam aluOp_t aluSra = 4'd7;
   localparam aluOp_t aluOr = 4'd8;
   localparam aluOp_t aluAnd = 4'd9;
   localparam aluOp_t aluPassB = 4'd10;

   // Writeback value source
   localparam resultSel_t resAlu = 2'd0;
   localparam resultSel_t resLoad = 2'd1;
   localparam resultSel_t resLink = 2'd2;

   localparam opcode_t opcOp = 7'b0110011;
   localparam opcode_t opcOpImm = 7'b0010011;
   localparam opcode_t opcLui = 7'b0110111;
   localparam opcode_t opcAuipc = 7'b0010111;
   localparam opcode_t opcJal = 7'b1101111;
   localparam opcode_t opcJalr = 7'b1100111;
   localparam opcode_t opcBranch = 7'b1100011;
   localparam opcode_t opcLoad = 7'b0000011;
   localparam opcode_t opcStore = 7'b0100011;

   // addi x0,x0,0
   localparam word_t nop = 32'h0000_0013;

   typedef struct packed {
      aluOp_t aluOp;
      logic useImm;
      // AUIPC and JAL put the PC on operand A
      logic usePc;
      // LUI forces operand A to zero
      logic zeroA;
      logic regWrite;
      logic memRead;
      logic memWrite;
      logic isBranch;
      logic [2:0] branchFunct3;
      logic isJal;
      logic isJalr;
      resultSel_t resultSel;
      regAddr_t rd;
      regAddr_t rs1;
      regAddr_t rs2;
      word_t imm;
   } decodeCtrl_t;

   typedef struct packed {
      logic valid;
      logic regWrite;
      regAddr_t rd;
      resultSel_t resultSel;
      word_t aluResult;
      word_t linkPc;
   } wbBus_t;

endpackage

`default_nettype wire
